//--- rtl/cnn_axi_pkg.sv
package cnn_axi_pkg;

	// Bus geometry
	localparam int ADDR_WIDTH = 5;   // Byte address
	localparam int DATA_WIDTH = 32;
	localparam int STRB_WIDTH = DATA_WIDTH / 8;

	typedef logic [DATA_WIDTH-1:0] axi_data_t;
	typedef logic [ADDR_WIDTH-1:0] axi_addr_t;
	typedef logic [STRB_WIDTH-1:0] axi_strb_t;

	// Register map
	localparam axi_addr_t REG_CONTROL     = 5'h00;
	localparam axi_addr_t REG_PIXEL       = 5'h04;
	localparam axi_addr_t REG_STATUS      = 5'h08;
	localparam axi_addr_t REG_RESULT_LO   = 5'h0C;
	localparam axi_addr_t REG_RESULT_HI   = 5'h10;   // Read pops the result queue
	localparam axi_addr_t REG_FRAME_COUNT = 5'h14;
	localparam axi_addr_t REG_ERROR       = 5'h18;

	// CONTROL command bits
	localparam int CTRL_START      = 0;
	localparam int CTRL_SOFT_RESET = 1;
	localparam int CTRL_FRAME_END  = 4;

	// STATUS bits
	localparam int STAT_BUSY      = 0;
	localparam int STAT_RES_AVAIL = 1;
	localparam int STAT_PIX_EMPTY = 2;
	localparam int STAT_PIX_FULL  = 3;

	// Sticky ERROR bits
	localparam int ERR_PIX_OVF  = 0;
	localparam int ERR_RES_OVF  = 1;
	localparam int ERR_PIX_IDLE = 2;

	localparam logic [1:0] RESP_OKAY = 2'b00;

endpackage

//--- rtl/cnn_core_pkg.sv
package cnn_core_pkg;

	typedef logic [7:0] pixel_t;            // Unsigned grey level
	typedef logic signed [7:0] weight_t;
	typedef logic signed [47:0] result_t;   // Frame sum

	localparam int NUM_TAPS  = 9;   // 3x3 kernel
	localparam int MAX_LANES = 4;

	// One fixed kernel per lane, taps in raster order
	localparam weight_t KERNELS [MAX_LANES][NUM_TAPS] = '{
		// Laplacian edge
		'{-1, -1, -1,
		  -1,  8, -1,
		  -1, -1, -1},
		// Sharpen
		'{ 0, -1,  0,
		  -1,  5, -1,
		   0, -1,  0},
		// Gaussian blur
		'{ 1,  2,  1,
		   2,  4,  2,
		   1,  2,  1},
		// Sobel x
		'{-1,  0,  1,
		  -2,  0,  2,
		  -1,  0,  1}
	};

endpackage

//--- rtl/cnn_if.sv
`timescale 1ns/1ns

// Register strobes between the AXI slave and the register block
interface reg_bus_if;
	logic                   wr_en;     // One-cycle write strobe
	cnn_axi_pkg::axi_addr_t wr_addr;
	cnn_axi_pkg::axi_data_t wr_data;
	cnn_axi_pkg::axi_strb_t wr_strb;
	logic                   rd_en;     // One-cycle read strobe
	cnn_axi_pkg::axi_addr_t rd_addr;
	cnn_axi_pkg::axi_data_t rd_data;   // Combinational, same cycle as rd_en

	modport slave (
		output wr_en, wr_addr, wr_data, wr_strb, rd_en, rd_addr,
		input  rd_data
	);

	modport regs (
		input  wr_en, wr_addr, wr_data, wr_strb, rd_en, rd_addr,
		output rd_data
	);
endinterface

// Command and pixel path into the core, result path back
interface core_if;
	logic                    start;          // Pulse
	logic                    clear;          // Pulse, soft reset
	logic                    pixel_valid;    // Pulse per pixel
	cnn_core_pkg::pixel_t    pixel;
	logic                    frame_end;      // Pulse
	logic                    busy;           // Level
	logic                    result_valid;   // One-cycle pulse
	cnn_core_pkg::result_t   result;

	modport ctrl (
		output start, clear, pixel_valid, pixel, frame_end,
		input  busy, result_valid, result
	);

	modport core (
		input  start, clear, pixel_valid, pixel, frame_end,
		output busy, result_valid, result
	);
endinterface

//--- rtl/sync_fifo.sv
`timescale 1ns/1ns

module sync_fifo #(
	parameter type T     = logic,
	parameter int  DEPTH = 4
) (
	input  logic clk,
	input  logic rst,
	input  logic flush,
	input  logic push,
	input  T     din,
	input  logic pop,
	output T     dout,
	output logic empty,
	output logic full
);

	localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	T                mem [DEPTH];
	logic [PW-1:0]   wr_ptr;
	logic [PW-1:0]   rd_ptr;
	logic [CW-1:0]   count;   // Occupancy
	logic            do_push;
	logic            do_pop;

	// Wrap for any depth, not only powers of two
	function automatic logic [PW-1:0] ptr_next(input logic [PW-1:0] p);
		return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign empty   = (count == '0);
	assign full    = (count == CW'(DEPTH));
	assign do_push = push & ~full;    // Overrun dropped
	assign do_pop  = pop & ~empty;    // Underrun ignored
	assign dout    = mem[rd_ptr];     // Head visible without latency

	always_ff @(posedge clk) begin
		if (do_push) mem[wr_ptr] <= din;
	end

	always_ff @(posedge clk) begin
		if (rst | flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) wr_ptr <= ptr_next(wr_ptr);
			if (do_pop) rd_ptr <= ptr_next(rd_ptr);
			count <= count + CW'(do_push) - CW'(do_pop);
		end
	end

endmodule

//--- rtl/cnn_mac_lane.sv
`timescale 1ns/1ns

module cnn_mac_lane #(
	parameter int LANE = 0
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  clear,
	input  logic                  valid,
	input  logic [3:0]            tap,
	input  cnn_core_pkg::pixel_t  pixel,
	output cnn_core_pkg::result_t acc
);

	cnn_core_pkg::weight_t weight;
	logic signed [16:0]    prod_q;   // 9b signed pixel times 8b weight
	logic                  prod_v;

	// Fixed kernel row for this lane
	assign weight = (tap < 4'(cnn_core_pkg::NUM_TAPS)) ? cnn_core_pkg::KERNELS[LANE][tap] : '0;

	// Stage 1 product
	always_ff @(posedge clk) begin
		prod_q <= $signed({1'b0, pixel}) * weight;   // Pixel zero-extended
	end

	always_ff @(posedge clk) begin
		if (rst) prod_v <= 1'b0;
		else prod_v <= valid & ~clear;
	end

	// Stage 2 accumulate, clear wins over a landing product
	always_ff @(posedge clk) begin
		if (rst | clear) begin
			acc <= '0;
		end else if (prod_v) begin
			acc <= acc + cnn_core_pkg::result_t'(prod_q);   // Sign-extended
		end
	end

endmodule

//--- rtl/cnn_core.sv
`timescale 1ns/1ns

module cnn_core #(
	parameter int NUM_LANES = 2
) (
	input logic  clk,
	input logic  rst,
	core_if.core ctl
);

	logic                  busy_q;
	logic [3:0]            tap;          // Pixel position mod NUM_TAPS
	logic [1:0]            drain_cnt;    // Counts down after frame end
	logic                  draining;
	logic                  run;          // Taking pixels
	logic                  lane_valid;
	logic                  lane_clear;
	cnn_core_pkg::result_t acc [NUM_LANES];
	cnn_core_pkg::result_t lane_sum;

	assign draining   = (drain_cnt != 2'd0);
	assign run        = busy_q & ~draining;
	assign lane_valid = ctl.pixel_valid & run;   // Stray pixels during drain dropped
	assign lane_clear = ctl.clear | (drain_cnt == 2'd1);   // Accs zero with busy fall

	for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
		cnn_mac_lane #(
			.LANE (l)
		) u_lane (
			.clk   (clk),
			.rst   (rst),
			.clear (lane_clear),
			.valid (lane_valid),
			.tap   (tap),
			.pixel (ctl.pixel),
			.acc   (acc[l])
		);
	end

	// Final adder across lanes
	always_comb begin
		lane_sum = '0;
		for (int l = 0; l < NUM_LANES; l++) begin
			lane_sum = lane_sum + acc[l];
		end
	end

	always_ff @(posedge clk) begin
		if (rst | ctl.clear) begin
			busy_q           <= 1'b0;
			tap              <= '0;
			drain_cnt        <= '0;
			ctl.result_valid <= 1'b0;
		end else begin
			ctl.result_valid <= 1'b0;
			if (ctl.start & ~busy_q) busy_q <= 1'b1;   // Start while busy ignored
			if (lane_valid) begin
				tap <= (tap == 4'(cnn_core_pkg::NUM_TAPS - 1)) ? '0 : tap + 1'b1;
			end
			if (ctl.frame_end & run) begin
				drain_cnt <= 2'd3;   // Pulse lands four cycles on
			end else if (draining) begin
				drain_cnt <= drain_cnt - 1'b1;
			end
			if (drain_cnt == 2'd1) begin
				busy_q           <= 1'b0;
				tap              <= '0;
				ctl.result_valid <= 1'b1;
			end
		end
	end

	// Lane sum captured in the last drain cycle
	always_ff @(posedge clk) begin
		if (drain_cnt == 2'd1) ctl.result <= lane_sum;
	end

	assign ctl.busy = busy_q;

endmodule

//--- rtl/cnn_axi_slave.sv
`timescale 1ns/1ns

module cnn_axi_slave (
	input  logic                   clk,
	input  logic                   rst,
	// Write address and data
	input  cnn_axi_pkg::axi_addr_t awaddr,
	input  logic                   awvalid,
	output logic                   awready,
	input  cnn_axi_pkg::axi_data_t wdata,
	input  cnn_axi_pkg::axi_strb_t wstrb,
	input  logic                   wvalid,
	output logic                   wready,
	// Write response
	output logic [1:0]             bresp,
	output logic                   bvalid,
	input  logic                   bready,
	// Read address
	input  cnn_axi_pkg::axi_addr_t araddr,
	input  logic                   arvalid,
	output logic                   arready,
	// Read data
	output cnn_axi_pkg::axi_data_t rdata,
	output logic [1:0]             rresp,
	output logic                   rvalid,
	input  logic                   rready,
	reg_bus_if.slave               bus
);

	logic wr_go;   // Write accepted this cycle
	logic rd_go;   // Read accepted this cycle

	// Address and data taken together, one beat only
	assign wr_go = awvalid & wvalid & ~bvalid;   // Held response blocks next write
	assign rd_go = arvalid & ~rvalid;            // Held read data blocks next read

	assign awready = wr_go;
	assign wready  = wr_go;
	assign arready = rd_go;

	// Strobes into the register block
	assign bus.wr_en   = wr_go;
	assign bus.wr_addr = awaddr;
	assign bus.wr_data = wdata;
	assign bus.wr_strb = wstrb;
	assign bus.rd_en   = rd_go;
	assign bus.rd_addr = araddr;

	// No slave errors in this design
	assign bresp = cnn_axi_pkg::RESP_OKAY;
	assign rresp = cnn_axi_pkg::RESP_OKAY;

	// Write response channel
	always_ff @(posedge clk) begin
		if (rst) begin
			bvalid <= 1'b0;
		end else if (wr_go) begin
			bvalid <= 1'b1;   // Next cycle after the strobe
		end else if (bready) begin
			bvalid <= 1'b0;
		end
	end

	// Read data channel
	always_ff @(posedge clk) begin
		if (rst) begin
			rvalid <= 1'b0;
		end else if (rd_go) begin
			rvalid <= 1'b1;
		end else if (rready) begin
			rvalid <= 1'b0;
		end
	end

	// Capture the decoded value, held until rready
	always_ff @(posedge clk) begin
		if (rd_go) begin
			rdata <= bus.rd_data;
		end
	end

endmodule

//--- rtl/cnn_regs.sv
`timescale 1ns/1ns

module cnn_regs #(
	parameter int PIX_DEPTH = 16,
	parameter int RES_DEPTH = 4
) (
	input logic     clk,
	input logic     rst,
	reg_bus_if.regs bus,
	core_if.ctrl    core
);

	logic                   wr_ctrl;    // Control write, low byte enabled
	logic                   wr_pix;     // Pixel write, low byte enabled
	logic                   rd_hi;      // Result high word read
	logic                   start_p;
	logic                   clear_p;
	logic                   fe_pend;    // Frame end waiting for the queue to drain
	logic                   pix_idle;   // Nobody to take a pixel
	logic                   pix_push;
	logic                   pix_pop;
	logic                   pix_empty;
	logic                   pix_full;
	cnn_core_pkg::pixel_t   pix_dout;
	logic                   res_empty;
	logic                   res_full;
	cnn_core_pkg::result_t  res_dout;
	cnn_core_pkg::result_t  res_head;
	cnn_axi_pkg::axi_data_t frame_cnt;
	logic [2:0]             err;
	cnn_axi_pkg::axi_data_t status;

	assign wr_ctrl = bus.wr_en & bus.wr_strb[0] & (bus.wr_addr == cnn_axi_pkg::REG_CONTROL);
	assign wr_pix  = bus.wr_en & bus.wr_strb[0] & (bus.wr_addr == cnn_axi_pkg::REG_PIXEL);
	assign rd_hi   = bus.rd_en & (bus.rd_addr == cnn_axi_pkg::REG_RESULT_HI);

	assign pix_idle = ~core.busy & ~start_p;   // A start in flight still counts
	assign pix_push = wr_pix & ~pix_full & ~pix_idle;
	assign pix_pop  = core.busy & ~pix_empty;   // One per cycle, core has no ready

	assign core.start       = start_p;
	assign core.clear       = clear_p;
	assign core.pixel_valid = pix_pop;
	assign core.pixel       = pix_dout;
	assign core.frame_end   = fe_pend & pix_empty;   // Only after the last pixel left

	// Command bits become single pulses
	always_ff @(posedge clk) begin
		if (rst) begin
			start_p <= 1'b0;
			clear_p <= 1'b0;
		end else begin
			start_p <= wr_ctrl & bus.wr_data[cnn_axi_pkg::CTRL_START];
			clear_p <= wr_ctrl & bus.wr_data[cnn_axi_pkg::CTRL_SOFT_RESET];
		end
	end

	always_ff @(posedge clk) begin
		if (rst | clear_p) begin
			fe_pend <= 1'b0;
		end else if (wr_ctrl & bus.wr_data[cnn_axi_pkg::CTRL_FRAME_END]) begin
			fe_pend <= 1'b1;
		end else if (pix_empty) begin
			fe_pend <= 1'b0;   // Issued this cycle
		end
	end

	// Frame counter and sticky errors, both wiped by soft reset
	always_ff @(posedge clk) begin
		if (rst | clear_p) begin
			frame_cnt <= '0;
			err       <= '0;
		end else begin
			if (core.result_valid) frame_cnt <= frame_cnt + 1'b1;
			if (wr_pix & pix_full) err[cnn_axi_pkg::ERR_PIX_OVF] <= 1'b1;
			if (wr_pix & pix_idle) err[cnn_axi_pkg::ERR_PIX_IDLE] <= 1'b1;
			if (core.result_valid & res_full) err[cnn_axi_pkg::ERR_RES_OVF] <= 1'b1;
		end
	end

	sync_fifo #(
		.T     (cnn_core_pkg::pixel_t),
		.DEPTH (PIX_DEPTH)
	) pixel_q (
		.clk   (clk),
		.rst   (rst),
		.flush (clear_p),
		.push  (pix_push),
		.din   (bus.wr_data[7:0]),
		.pop   (pix_pop),
		.dout  (pix_dout),
		.empty (pix_empty),
		.full  (pix_full)
	);

	// Push while full is dropped inside the FIFO
	sync_fifo #(
		.T     (cnn_core_pkg::result_t),
		.DEPTH (RES_DEPTH)
	) result_q (
		.clk   (clk),
		.rst   (rst),
		.flush (clear_p),
		.push  (core.result_valid),
		.din   (core.result),
		.pop   (rd_hi),
		.dout  (res_dout),
		.empty (res_empty),
		.full  (res_full)
	);

	assign res_head = res_empty ? '0 : res_dout;   // Hide stale entries

	always_comb begin
		status = '0;
		status[cnn_axi_pkg::STAT_BUSY]      = core.busy;
		status[cnn_axi_pkg::STAT_RES_AVAIL] = ~res_empty;
		status[cnn_axi_pkg::STAT_PIX_EMPTY] = pix_empty;
		status[cnn_axi_pkg::STAT_PIX_FULL]  = pix_full;
	end

	// Read decode, control and pixel read back as zero
	always_comb begin
		case (bus.rd_addr)
			cnn_axi_pkg::REG_STATUS:      bus.rd_data = status;
			cnn_axi_pkg::REG_RESULT_LO:   bus.rd_data = res_head[31:0];
			cnn_axi_pkg::REG_RESULT_HI:   bus.rd_data = {16'b0, res_head[47:32]};
			cnn_axi_pkg::REG_FRAME_COUNT: bus.rd_data = frame_cnt;
			cnn_axi_pkg::REG_ERROR:       bus.rd_data = {29'b0, err};
			default:                      bus.rd_data = '0;
		endcase
	end

endmodule

//--- rtl/myip_cnn.sv
`timescale 1ns/1ns

module myip_cnn #(
	parameter int NUM_LANES = 2,    // 1 to MAX_LANES
	parameter int PIX_DEPTH = 16,
	parameter int RES_DEPTH = 4
) (
	input  logic                              s00_axi_cnn_aclk,
	input  logic                              rst,
	input  logic [cnn_axi_pkg::ADDR_WIDTH-1:0] s00_axi_cnn_awaddr,
	input  logic                              s00_axi_cnn_awvalid,
	output logic                              s00_axi_cnn_awready,
	input  logic [cnn_axi_pkg::DATA_WIDTH-1:0] s00_axi_cnn_wdata,
	input  logic [cnn_axi_pkg::STRB_WIDTH-1:0] s00_axi_cnn_wstrb,
	input  logic                              s00_axi_cnn_wvalid,
	output logic                              s00_axi_cnn_wready,
	output logic [1:0]                        s00_axi_cnn_bresp,
	output logic                              s00_axi_cnn_bvalid,
	input  logic                              s00_axi_cnn_bready,
	input  logic [cnn_axi_pkg::ADDR_WIDTH-1:0] s00_axi_cnn_araddr,
	input  logic                              s00_axi_cnn_arvalid,
	output logic                              s00_axi_cnn_arready,
	output logic [cnn_axi_pkg::DATA_WIDTH-1:0] s00_axi_cnn_rdata,
	output logic [1:0]                        s00_axi_cnn_rresp,
	output logic                              s00_axi_cnn_rvalid,
	input  logic                              s00_axi_cnn_rready
);

	reg_bus_if reg_bus ();   // Slave to register block
	core_if    core_bus ();  // Register block to core

	cnn_axi_slave u_axi (
		.clk     (s00_axi_cnn_aclk),
		.rst     (rst),
		.awaddr  (s00_axi_cnn_awaddr),
		.awvalid (s00_axi_cnn_awvalid),
		.awready (s00_axi_cnn_awready),
		.wdata   (s00_axi_cnn_wdata),
		.wstrb   (s00_axi_cnn_wstrb),
		.wvalid  (s00_axi_cnn_wvalid),
		.wready  (s00_axi_cnn_wready),
		.bresp   (s00_axi_cnn_bresp),
		.bvalid  (s00_axi_cnn_bvalid),
		.bready  (s00_axi_cnn_bready),
		.araddr  (s00_axi_cnn_araddr),
		.arvalid (s00_axi_cnn_arvalid),
		.arready (s00_axi_cnn_arready),
		.rdata   (s00_axi_cnn_rdata),
		.rresp   (s00_axi_cnn_rresp),
		.rvalid  (s00_axi_cnn_rvalid),
		.rready  (s00_axi_cnn_rready),
		.bus     (reg_bus.slave)
	);

	cnn_regs #(
		.PIX_DEPTH (PIX_DEPTH),
		.RES_DEPTH (RES_DEPTH)
	) u_regs (
		.clk  (s00_axi_cnn_aclk),
		.rst  (rst),
		.bus  (reg_bus.regs),
		.core (core_bus.ctrl)
	);

	cnn_core #(
		.NUM_LANES (NUM_LANES)
	) u_core (
		.clk (s00_axi_cnn_aclk),
		.rst (rst),
		.ctl (core_bus.core)
	);

endmodule

//--- test/tb_axi_tasks.svh
`ifndef TB_AXI_TASKS_SVH
`define TB_AXI_TASKS_SVH

// Single-beat write, bready withheld for a random stretch
task automatic write_reg(
	input cnn_axi_pkg::axi_addr_t addr,
	input cnn_axi_pkg::axi_data_t data,
	input cnn_axi_pkg::axi_strb_t strb
);
	int hold;
	txns++;
	hold = $random(seed) & 7;
	@(posedge clk);
	awaddr  <= addr;
	awvalid <= 1'b1;
	wdata   <= data;
	wstrb   <= strb;
	wvalid  <= 1'b1;
	bready  <= 1'b0;
	do @(negedge clk); while (!awready);   // Accepted on the coming edge
	@(posedge clk);
	awvalid <= 1'b0;
	wvalid  <= 1'b0;
	repeat (hold) @(posedge clk);
	bready <= 1'b1;
	do @(negedge clk); while (!bvalid);
	@(posedge clk);
	bready <= 1'b0;
endtask

// Single-beat read, rready withheld for a random stretch
task automatic read_reg(
	input  cnn_axi_pkg::axi_addr_t addr,
	output cnn_axi_pkg::axi_data_t data
);
	int hold;
	txns++;
	hold = $random(seed) & 7;
	@(posedge clk);
	araddr  <= addr;
	arvalid <= 1'b1;
	rready  <= 1'b0;
	do @(negedge clk); while (!arready);
	@(posedge clk);
	arvalid <= 1'b0;
	repeat (hold) @(posedge clk);
	rready <= 1'b1;
	do @(negedge clk); while (!rvalid);
	data = rdata;   // Stable mid-cycle
	@(posedge clk);
	rready <= 1'b0;
endtask

`endif

//--- test/tb_cnn.sv
`timescale 1ns/1ns

module tb_cnn;

	localparam int NUM_LANES = 2;
	localparam int PIX_DEPTH = 16;
	localparam int RES_DEPTH = 4;

	// Expected STATUS words
	localparam cnn_axi_pkg::axi_data_t ST_IDLE = 32'd1 << cnn_axi_pkg::STAT_PIX_EMPTY;
	localparam cnn_axi_pkg::axi_data_t ST_RESULT =
		ST_IDLE | (32'd1 << cnn_axi_pkg::STAT_RES_AVAIL);
	localparam cnn_axi_pkg::axi_data_t START_CMD = 32'd1 << cnn_axi_pkg::CTRL_START;

	logic                   clk = 1'b0;
	logic                   rst;
	cnn_axi_pkg::axi_addr_t awaddr;
	logic                   awvalid;
	logic                   awready;
	cnn_axi_pkg::axi_data_t wdata;
	cnn_axi_pkg::axi_strb_t wstrb;
	logic                   wvalid;
	logic                   wready;
	logic [1:0]             bresp;
	logic                   bvalid;
	logic                   bready;
	cnn_axi_pkg::axi_addr_t araddr;
	logic                   arvalid;
	logic                   arready;
	cnn_axi_pkg::axi_data_t rdata;
	logic [1:0]             rresp;
	logic                   rvalid;
	logic                   rready;

	int     seed = 14402;
	int     txns = 0;     // Bus transactions issued
	int     cycles = 0;
	int     checks = 0;
	int     errors = 0;
	int     frames = 0;   // Mirrors FRAME_COUNT
	longint exp_q [$];    // Model results in arrival order

	// Previous-cycle view of the bus for the protocol checks
	logic                   prev_awready = 1'b0;
	logic                   prev_arready = 1'b0;
	logic                   prev_bvalid = 1'b0;
	logic                   prev_bready = 1'b0;
	logic                   prev_rvalid = 1'b0;
	logic                   prev_rready = 1'b0;
	cnn_axi_pkg::axi_data_t prev_rdata = '0;

	always #2 clk = ~clk;

	`include "tb_axi_tasks.svh"

	myip_cnn #(
		.NUM_LANES (NUM_LANES),
		.PIX_DEPTH (PIX_DEPTH),
		.RES_DEPTH (RES_DEPTH)
	) uut (
		.s00_axi_cnn_aclk    (clk),
		.rst                 (rst),
		.s00_axi_cnn_awaddr  (awaddr),
		.s00_axi_cnn_awvalid (awvalid),
		.s00_axi_cnn_awready (awready),
		.s00_axi_cnn_wdata   (wdata),
		.s00_axi_cnn_wstrb   (wstrb),
		.s00_axi_cnn_wvalid  (wvalid),
		.s00_axi_cnn_wready  (wready),
		.s00_axi_cnn_bresp   (bresp),
		.s00_axi_cnn_bvalid  (bvalid),
		.s00_axi_cnn_bready  (bready),
		.s00_axi_cnn_araddr  (araddr),
		.s00_axi_cnn_arvalid (arvalid),
		.s00_axi_cnn_arready (arready),
		.s00_axi_cnn_rdata   (rdata),
		.s00_axi_cnn_rresp   (rresp),
		.s00_axi_cnn_rvalid  (rvalid),
		.s00_axi_cnn_rready  (rready)
	);

	// Combined weight of tap t over the active lanes
	function automatic int tap_weight(input int t);
		int w;
		w = 0;
		for (int l = 0; l < NUM_LANES; l++) begin
			w += int'(cnn_core_pkg::KERNELS[l][t]);
		end
		return w;
	endfunction

	task automatic expect_reg(
		input cnn_axi_pkg::axi_addr_t addr,
		input cnn_axi_pkg::axi_data_t exp,
		input string                  name
	);
		cnn_axi_pkg::axi_data_t got;
		read_reg(addr, got);
		checks++;
		assert (got == exp) else begin
			errors++;
			$display("ERROR %s read 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	// Poll STATUS until the core drops busy
	task automatic wait_idle();
		cnn_axi_pkg::axi_data_t st;
		int                     polls;
		polls = 0;
		st = 32'd1 << cnn_axi_pkg::STAT_BUSY;
		while (st[cnn_axi_pkg::STAT_BUSY] && polls < 40) begin
			read_reg(cnn_axi_pkg::REG_STATUS, st);
			polls++;
		end
		assert (!st[cnn_axi_pkg::STAT_BUSY]) else begin
			errors++;
			$display("Frame still busy after %0d status polls", polls);
		end
	endtask

	// Start, 5 to 20 random pixels and frame end with the model result queued
	task automatic send_frame(input bit strb_probe);
		longint               sum;
		int                   rnd;
		int                   len;
		cnn_core_pkg::pixel_t p;
		sum = 0;
		rnd = $random(seed);
		len = 5 + (rnd & 15);
		write_reg(cnn_axi_pkg::REG_CONTROL, START_CMD, 4'hF);
		for (int i = 0; i < len; i++) begin
			rnd = $random(seed);
			p = rnd[7:0];
			write_reg(cnn_axi_pkg::REG_PIXEL, {24'h0, p}, 4'hF);
			sum += longint'(p) * longint'(tap_weight(i % cnn_core_pkg::NUM_TAPS));
		end
		if (strb_probe) begin
			write_reg(cnn_axi_pkg::REG_PIXEL, 32'hC3, 4'b1110);   // Low lane off, ignored
		end
		write_reg(cnn_axi_pkg::REG_CONTROL, 32'd1 << cnn_axi_pkg::CTRL_FRAME_END, 4'hF);
		exp_q.push_back(sum);
		frames++;
		wait_idle();
	endtask

	// Oldest model result against LO then HI where the HI read pops
	task automatic check_result();
		longint                 e;
		cnn_axi_pkg::axi_data_t hi;
		e = exp_q.pop_front();
		hi = {16'h0, e[47:32]};
		expect_reg(cnn_axi_pkg::REG_RESULT_LO, e[31:0], "RESULT_LO");
		expect_reg(cnn_axi_pkg::REG_RESULT_HI, hi, "RESULT_HI");
	endtask

	// AXI handshake rules sampled mid-cycle
	always @(negedge clk) begin
		if (rst) begin
			assert (!awready && !wready && !arready && !bvalid && !rvalid) else begin
				errors++;
				$display("Bus handshake outputs not idle during reset at %0t", $time);
			end
		end else begin
			assert (awready == wready && awready == (awvalid && wvalid && !bvalid)) else begin
				errors++;
				$display("awready or wready out of step with the write request at %0t", $time);
			end
			assert (arready == (arvalid && !rvalid)) else begin
				errors++;
				$display("arready out of step with the read request at %0t", $time);
			end
			assert (!prev_awready || bvalid) else begin
				errors++;
				$display("No bvalid after an accepted write at %0t", $time);
			end
			assert (!(prev_bvalid && !prev_bready) || bvalid) else begin
				errors++;
				$display("bvalid dropped while bready was low at %0t", $time);
			end
			assert (!prev_arready || rvalid) else begin
				errors++;
				$display("No rvalid after an accepted read at %0t", $time);
			end
			assert (!(prev_rvalid && !prev_rready) || (rvalid && rdata == prev_rdata)) else begin
				errors++;
				$display("Read data not held while rready was low at %0t", $time);
			end
			assert (!bvalid || bresp == cnn_axi_pkg::RESP_OKAY) else begin
				errors++;
				$display("ERROR bresp 0x%h expected 0x%h", bresp, cnn_axi_pkg::RESP_OKAY);
			end
			assert (!rvalid || rresp == cnn_axi_pkg::RESP_OKAY) else begin
				errors++;
				$display("ERROR rresp 0x%h expected 0x%h", rresp, cnn_axi_pkg::RESP_OKAY);
			end
		end
		prev_awready = awready;
		prev_arready = arready;
		prev_bvalid  = bvalid;
		prev_bready  = bready;
		prev_rvalid  = rvalid;
		prev_rready  = rready;
		prev_rdata   = rdata;
	end

	// Limit grows with every bus transaction issued
	always @(posedge clk) begin
		cycles++;
		if (cycles > 200 * txns + 500) begin
			$display("Timeout after %0d cycles with %0d bus transactions issued", cycles, txns);
			$display("Checks: %0d, errors: %0d", checks, errors);
			$display("Verification failed");
			$finish;
		end
	end

	initial begin
		rst     = 1'b1;
		awaddr  = '0;
		awvalid = 1'b0;
		wdata   = '0;
		wstrb   = '0;
		wvalid  = 1'b0;
		bready  = 1'b0;
		araddr  = '0;
		arvalid = 1'b0;
		rready  = 1'b0;
		repeat (2) @(posedge clk);
		rst <= 1'b0;

		// Reset state
		expect_reg(cnn_axi_pkg::REG_STATUS, ST_IDLE, "STATUS");
		expect_reg(cnn_axi_pkg::REG_FRAME_COUNT, 32'h0, "FRAME_COUNT");
		expect_reg(cnn_axi_pkg::REG_ERROR, 32'h0, "ERROR");

		// Low byte lane off so nothing happens
		write_reg(cnn_axi_pkg::REG_PIXEL, 32'hAB, 4'b1110);
		write_reg(cnn_axi_pkg::REG_CONTROL, START_CMD, 4'b1110);
		expect_reg(cnn_axi_pkg::REG_STATUS, ST_IDLE, "STATUS");
		expect_reg(cnn_axi_pkg::REG_ERROR, 32'h0, "ERROR");

		for (int f = 1; f <= 3; f++) begin
			send_frame(f == 1);
			check_result();
			expect_reg(cnn_axi_pkg::REG_FRAME_COUNT, frames, "FRAME_COUNT");
		end

		// Two results queued before readback
		send_frame(1'b0);
		send_frame(1'b0);
		expect_reg(cnn_axi_pkg::REG_STATUS, ST_RESULT, "STATUS");
		check_result();
		expect_reg(cnn_axi_pkg::REG_STATUS, ST_RESULT, "STATUS");
		check_result();
		expect_reg(cnn_axi_pkg::REG_STATUS, ST_IDLE, "STATUS");

		// Stray pixel while idle must not reach the next frame
		write_reg(cnn_axi_pkg::REG_PIXEL, 32'h5A, 4'hF);
		expect_reg(cnn_axi_pkg::REG_ERROR, 32'd1 << cnn_axi_pkg::ERR_PIX_IDLE, "ERROR");
		send_frame(1'b0);
		check_result();

		// One frame more than the result queue holds
		for (int k = 0; k <= RES_DEPTH; k++) begin
			send_frame(1'b0);
		end
		expect_reg(cnn_axi_pkg::REG_ERROR,
			(32'd1 << cnn_axi_pkg::ERR_PIX_IDLE) | (32'd1 << cnn_axi_pkg::ERR_RES_OVF),
			"ERROR");
		expect_reg(cnn_axi_pkg::REG_FRAME_COUNT, frames, "FRAME_COUNT");
		check_result();   // Oldest entry survives the overflow
		expect_reg(cnn_axi_pkg::REG_STATUS, ST_RESULT, "STATUS");

		// Soft reset with results still queued
		write_reg(cnn_axi_pkg::REG_CONTROL, 32'd1 << cnn_axi_pkg::CTRL_SOFT_RESET, 4'hF);
		exp_q.delete();
		frames = 0;
		expect_reg(cnn_axi_pkg::REG_STATUS, ST_IDLE, "STATUS");
		expect_reg(cnn_axi_pkg::REG_ERROR, 32'h0, "ERROR");
		expect_reg(cnn_axi_pkg::REG_FRAME_COUNT, 32'h0, "FRAME_COUNT");
		send_frame(1'b0);
		check_result();
		expect_reg(cnn_axi_pkg::REG_FRAME_COUNT, frames, "FRAME_COUNT");

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

//--- vlog.f
+incdir+test
rtl/cnn_axi_pkg.sv
rtl/cnn_core_pkg.sv
rtl/cnn_if.sv
rtl/sync_fifo.sv
rtl/cnn_mac_lane.sv
rtl/cnn_core.sv
rtl/cnn_axi_slave.sv
rtl/cnn_regs.sv
rtl/myip_cnn.sv
test/tb_cnn.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_cnn
FILELIST  = vlog.f
PASS_MSG  = Verification passed

.PHONY: sim clean

# Build, run, then look for the pass line in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
